// File: filelist.f
+incdir+logic
logic/grid_pkg.sv
logic/cell_memory.sv
logic/random_source.sv
logic/ship_placer.sv
logic/shot_marker.sv
logic/grid_engine.sv
tests/tb_clock.sv
tests/grid_checker.sv
tests/grid_assertions.sv
tests/grid_engine_tb.sv

// File: logic/cell_memory.sv
`timescale 1ns/10ps
`include "grid_settings.svh"

module cell_memory (
	input  logic                   clk_in,
	input  logic                   wait_mouse_reset,
	input  logic                   placement_done,
	input  grid_pkg::coord_t       place_x,
	input  grid_pkg::coord_t       place_y,
	input  logic                   place_we,
	input  grid_pkg::cell_status_t place_status,
	input  grid_pkg::coord_t       mark_x,
	input  grid_pkg::coord_t       mark_y,
	input  logic                   mark_we,
	input  grid_pkg::cell_status_t mark_status,
	output grid_pkg::cell_status_t port_status,
	input  grid_pkg::coord_t       pointer_x,
	input  grid_pkg::coord_t       pointer_y,
	output grid_pkg::cell_status_t pointer_status
);

	grid_pkg::cell_status_t cells [0:`GRID_SIZE*`GRID_SIZE-1];  // row major, y high

	logic [2*`COORD_W-1:0]  port_addr;     // address of the shared port
	logic [2*`COORD_W-1:0]  pointer_addr;  // address of the scan port
	logic                   port_we;
	grid_pkg::cell_status_t port_wdata;

	// ----------------------------------------------------------
	// port arbitration by game phase
	// ----------------------------------------------------------
	assign port_addr  = placement_done ? {mark_y, mark_x} : {place_y, place_x};
	assign port_we    = placement_done ? mark_we : place_we;     // placer owns it until done
	assign port_wdata = placement_done ? mark_status : place_status;

	assign port_status  = cells[port_addr];  // combinational read for check and mark
	assign pointer_addr = {pointer_y, pointer_x};

	always_ff @(posedge clk_in) begin
		if (wait_mouse_reset) begin
			for (int i = 0; i < `GRID_SIZE*`GRID_SIZE; i++) begin
				cells[i] <= `ST_EMPTY;  // whole board back to water
			end
			pointer_status <= `ST_EMPTY;
		end else begin
			if (port_we) begin
				cells[port_addr] <= port_wdata;  // single cycle write
			end
			pointer_status <= cells[pointer_addr];  // scan lags address by one clock
		end
	end

endmodule

// File: logic/grid_engine.sv
`timescale 1ns/10ps

module grid_engine (
	input  logic                   clk_in,
	input  logic                   wait_mouse_reset,
	input  logic                   start,
	input  grid_pkg::coord_t       mouse_x,
	input  grid_pkg::coord_t       mouse_y,
	input  logic                   mouse_click,
	input  grid_pkg::coord_t       pointer_x,
	input  grid_pkg::coord_t       pointer_y,
	output grid_pkg::cell_status_t pointer_status,
	output logic                   placement_done
);

	// ----------------------------------------------------------
	// internal nets
	// ----------------------------------------------------------
	grid_pkg::ship_len_t    ship_len;
	logic                   rnd_orient;
	grid_pkg::coord_t       rnd_along;
	grid_pkg::coord_t       rnd_cross;
	grid_pkg::cell_status_t port_status;   // shared read, placer or marker
	grid_pkg::coord_t       place_x;
	grid_pkg::coord_t       place_y;
	logic                   place_we;
	grid_pkg::cell_status_t place_status;
	grid_pkg::coord_t       mark_x;
	grid_pkg::coord_t       mark_y;
	logic                   mark_we;
	grid_pkg::cell_status_t mark_status;

	cell_memory cell_memory_inst (
		.clk_in(clk_in), .wait_mouse_reset(wait_mouse_reset),
		.placement_done(placement_done),
		.place_x(place_x), .place_y(place_y), .place_we(place_we),
		.place_status(place_status),
		.mark_x(mark_x), .mark_y(mark_y), .mark_we(mark_we), .mark_status(mark_status),
		.port_status(port_status),
		.pointer_x(pointer_x), .pointer_y(pointer_y), .pointer_status(pointer_status)
	);

	random_source random_source_inst (
		.clk_in(clk_in), .wait_mouse_reset(wait_mouse_reset), .ship_len(ship_len),
		.rnd_orient(rnd_orient), .rnd_along(rnd_along), .rnd_cross(rnd_cross)
	);

	ship_placer ship_placer_inst (
		.clk_in(clk_in), .wait_mouse_reset(wait_mouse_reset), .start(start),
		.rnd_orient(rnd_orient), .rnd_along(rnd_along), .rnd_cross(rnd_cross),
		.ship_len(ship_len), .port_status(port_status),
		.place_x(place_x), .place_y(place_y), .place_we(place_we),
		.place_status(place_status), .placement_done(placement_done)
	);

	shot_marker shot_marker_inst (
		.clk_in(clk_in), .wait_mouse_reset(wait_mouse_reset),
		.placement_done(placement_done),  // enables the play phase
		.mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_click(mouse_click),
		.port_status(port_status),
		.mark_x(mark_x), .mark_y(mark_y), .mark_we(mark_we), .mark_status(mark_status)
	);

endmodule

// File: logic/grid_pkg.sv
`include "grid_settings.svh"

package grid_pkg;

	typedef logic [`COORD_W-1:0]  coord_t;        // row or column index
	typedef logic [`STATUS_W-1:0] cell_status_t;  // contents of one cell
	typedef logic [2:0]           ship_len_t;     // 2 to 4 in practice
	typedef logic [2:0]           ship_idx_t;     // 0 to SHIP_COUNT-1

	// placement fsm
	typedef enum logic [2:0] {
		PL_IDLE,   // wait for start
		PL_PICK,   // latch random origin
		PL_CHECK,  // read covered cells
		PL_WRITE,  // mark covered cells
		PL_NEXT,   // advance ship index
		PL_DONE    // fleet placed, hold
	} place_state_t;

	// click marker fsm
	typedef enum logic [1:0] {
		MK_IDLE,
		MK_WRITE,
		MK_RELEASE
	} mark_state_t;

endpackage

// File: logic/grid_settings.svh
`ifndef GRID_SETTINGS_SVH
`define GRID_SETTINGS_SVH

// ----------------------------------------------------------
// board geometry
// ----------------------------------------------------------
`define GRID_SIZE   8                // cells per side
`define COORD_W     3                // bits for one coordinate
`define STATUS_W    4                // bits for one cell state

// ----------------------------------------------------------
// fleet
// ----------------------------------------------------------
`define SHIP_COUNT  6                // ships placed per game
`define SHIP_LEN_0  3'd4             // two long ships first
`define SHIP_LEN_1  3'd4
`define SHIP_LEN_2  3'd3             // then two medium
`define SHIP_LEN_3  3'd3
`define SHIP_LEN_4  3'd2             // two short ones last
`define SHIP_LEN_5  3'd2

// ----------------------------------------------------------
// cell status codes
// ----------------------------------------------------------
`define ST_EMPTY    4'd0             // water, not shot
`define ST_MISS     4'd1             // water, shot
`define ST_SHIP     4'd5             // ship, not shot
`define ST_HIT      4'd10            // ship, shot

`define LFSR_SEED   31'h4AB4_4FC1    // any nonzero value works

`endif

// File: logic/random_source.sv
`timescale 1ns/10ps
`include "grid_settings.svh"

module random_source (
	input  logic                clk_in,
	input  logic                wait_mouse_reset,
	input  grid_pkg::ship_len_t ship_len,
	output logic                rnd_orient,
	output grid_pkg::coord_t    rnd_along,
	output grid_pkg::coord_t    rnd_cross
);

	logic [30:0]      lfsr;       // x^31 + x^28 + 1
	grid_pkg::coord_t along_raw;  // 0 to 7 before folding
	grid_pkg::coord_t along_max;  // last legal origin along the ship

	always_ff @(posedge clk_in) begin
		if (wait_mouse_reset) begin
			lfsr <= `LFSR_SEED;
		end else begin
			lfsr <= {lfsr[29:0], lfsr[30] ^ lfsr[27]};  // free running
		end
	end

	assign along_raw = lfsr[3:1];
	assign along_max = grid_pkg::coord_t'(`GRID_SIZE - ship_len);  // 4, 5 or 6

	// fold once so the ship never runs off the board
	assign rnd_along  = (along_raw > along_max) ? along_raw - along_max - 3'd1 : along_raw;
	assign rnd_cross  = lfsr[6:4];  // any row or column is fine across the ship
	assign rnd_orient = lfsr[0];    // 0 horizontal, 1 vertical

endmodule

// File: logic/ship_placer.sv
`timescale 1ns/10ps
`include "grid_settings.svh"

module ship_placer (
	input  logic                   clk_in,
	input  logic                   wait_mouse_reset,
	input  logic                   start,
	input  logic                   rnd_orient,
	input  grid_pkg::coord_t       rnd_along,
	input  grid_pkg::coord_t       rnd_cross,
	output grid_pkg::ship_len_t    ship_len,
	input  grid_pkg::cell_status_t port_status,
	output grid_pkg::coord_t       place_x,
	output grid_pkg::coord_t       place_y,
	output logic                   place_we,
	output grid_pkg::cell_status_t place_status,
	output logic                   placement_done
);

	grid_pkg::place_state_t state;
	grid_pkg::ship_idx_t    ship_idx;      // ship being placed
	grid_pkg::ship_len_t    step;          // offset along the ship
	logic                   orient;        // latched orientation
	grid_pkg::coord_t       origin_along;  // first cell along the ship
	grid_pkg::coord_t       origin_cross;  // fixed row or column
	grid_pkg::coord_t       along_pos;
	logic                   last_step;

	// ----------------------------------------------------------
	// fleet table
	// ----------------------------------------------------------
	always_comb begin
		case (ship_idx)
			3'd0:    ship_len = `SHIP_LEN_0;
			3'd1:    ship_len = `SHIP_LEN_1;
			3'd2:    ship_len = `SHIP_LEN_2;
			3'd3:    ship_len = `SHIP_LEN_3;
			3'd4:    ship_len = `SHIP_LEN_4;
			default: ship_len = `SHIP_LEN_5;
		endcase
	end

	assign along_pos = origin_along + step;           // never wraps, origin is folded
	assign place_x   = orient ? origin_cross : along_pos;
	assign place_y   = orient ? along_pos : origin_cross;
	assign last_step = (step == ship_len - 3'd1);

	assign place_we       = (state == grid_pkg::PL_WRITE);
	assign place_status   = `ST_SHIP;
	assign placement_done = (state == grid_pkg::PL_DONE);  // sticky until reset

	// ----------------------------------------------------------
	// placement fsm
	// ----------------------------------------------------------
	always_ff @(posedge clk_in) begin
		if (wait_mouse_reset) begin
			state        <= grid_pkg::PL_IDLE;
			ship_idx     <= '0;
			step         <= '0;
			orient       <= 1'b0;
			origin_along <= '0;
			origin_cross <= '0;
		end else begin
			case (state)
				grid_pkg::PL_IDLE: begin
					if (start) begin  // start ignored in any other state
						ship_idx <= '0;
						state    <= grid_pkg::PL_PICK;
					end
				end
				grid_pkg::PL_PICK: begin
					orient       <= rnd_orient;
					origin_along <= rnd_along;  // already in range for ship_len
					origin_cross <= rnd_cross;
					step         <= '0;
					state        <= grid_pkg::PL_CHECK;
				end
				grid_pkg::PL_CHECK: begin
					if (port_status != `ST_EMPTY) begin
						state <= grid_pkg::PL_PICK;  // overlap, try a new spot
					end else if (last_step) begin
						step  <= '0;
						state <= grid_pkg::PL_WRITE;
					end else begin
						step <= step + 3'd1;
					end
				end
				grid_pkg::PL_WRITE: begin
					if (last_step) begin
						state <= grid_pkg::PL_NEXT;
					end else begin
						step <= step + 3'd1;
					end
				end
				grid_pkg::PL_NEXT: begin
					if (ship_idx == grid_pkg::ship_idx_t'(`SHIP_COUNT - 1)) begin
						state <= grid_pkg::PL_DONE;
					end else begin
						ship_idx <= ship_idx + 3'd1;
						state    <= grid_pkg::PL_PICK;
					end
				end
				default: begin
					state <= grid_pkg::PL_DONE;  // parked for the play phase
				end
			endcase
		end
	end

endmodule

// File: logic/shot_marker.sv
`timescale 1ns/10ps
`include "grid_settings.svh"

module shot_marker (
	input  logic                   clk_in,
	input  logic                   wait_mouse_reset,
	input  logic                   placement_done,
	input  grid_pkg::coord_t       mouse_x,
	input  grid_pkg::coord_t       mouse_y,
	input  logic                   mouse_click,
	input  grid_pkg::cell_status_t port_status,
	output grid_pkg::coord_t       mark_x,
	output grid_pkg::coord_t       mark_y,
	output logic                   mark_we,
	output grid_pkg::cell_status_t mark_status
);

	grid_pkg::mark_state_t state;
	logic                  click_d;    // click one cycle ago
	logic                  click_rise;

	// shot transition table
	function automatic grid_pkg::cell_status_t shot_result(input grid_pkg::cell_status_t cur);
		case (cur)
			`ST_EMPTY: shot_result = `ST_MISS;
			4'd2:      shot_result = 4'd3;
			4'd4:      shot_result = 4'd9;
			`ST_SHIP:  shot_result = `ST_HIT;
			4'd6:      shot_result = 4'd11;
			4'd7:      shot_result = 4'd13;
			4'd8:      shot_result = 4'd14;
			4'd12:     shot_result = 4'd15;
			default:   shot_result = cur;  // already shot, leave as is
		endcase
	endfunction

	assign click_rise  = mouse_click & ~click_d;
	assign mark_we     = (state == grid_pkg::MK_WRITE);
	assign mark_status = shot_result(port_status);  // port points at the latched cell

	always_ff @(posedge clk_in) begin
		if (wait_mouse_reset) begin
			state   <= grid_pkg::MK_IDLE;
			click_d <= 1'b0;
			mark_x  <= '0;
			mark_y  <= '0;
		end else begin
			click_d <= mouse_click;  // tracked during placement too
			case (state)
				grid_pkg::MK_IDLE: begin
					if (placement_done && click_rise) begin
						mark_x <= mouse_x;
						mark_y <= mouse_y;
						state  <= grid_pkg::MK_WRITE;
					end
				end
				grid_pkg::MK_WRITE: begin
					state <= grid_pkg::MK_RELEASE;  // one write per press
				end
				default: begin
					if (!mouse_click) begin
						state <= grid_pkg::MK_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the grid engine testbench with Verilator
verilator --binary --timing --assert --top-module grid_engine_tb -f filelist.f \
	&& ./obj_dir/Vgrid_engine_tb | tee sim.log || exit 1
grep -q '>>> FAIL' sim.log && exit 1 || grep -q '>>> PASS' sim.log

// File: tests/grid_assertions.sv
`timescale 1ns/10ps

module grid_assertions (
	input logic                   clk_in,
	input logic                   wait_mouse_reset,
	input logic                   placement_done,
	input logic                   mark_we,
	input grid_pkg::cell_status_t pointer_status
);

	// done is sticky once the fleet is placed
	done_sticky: assert property (@(posedge clk_in) disable iff (wait_mouse_reset)
		$past(placement_done) |-> placement_done)
		else $error("placement_done fell without a reset");

	no_early_mark: assert property (@(posedge clk_in) disable iff (wait_mouse_reset)
		mark_we |-> placement_done)
		else $error("mark_we high while placement is still running");

	scan_known: assert property (@(posedge clk_in) disable iff (wait_mouse_reset)
		!$isunknown(pointer_status))
		else $error("pointer_status is unknown after reset");

endmodule

bind grid_engine grid_assertions grid_assertions_inst (
	.clk_in(clk_in), .wait_mouse_reset(wait_mouse_reset), .placement_done(placement_done),
	.mark_we(mark_we), .pointer_status(pointer_status)
);

// File: tests/grid_checker.sv
`timescale 1ns/10ps
`include "grid_settings.svh"

module grid_checker (
	input  logic                   clk_in,
	input  logic                   placement_done,
	input  logic                   mark_we,         // marker write strobe inside the DUT
	input  grid_pkg::coord_t       pointer_x,
	input  grid_pkg::coord_t       pointer_y,
	input  grid_pkg::cell_status_t pointer_status,
	input  logic                   scan_req,        // scan address valid this cycle
	input  logic [1:0]             scan_mode,       // 0 expect empty, 1 capture, 2 compare
	input  logic                   click_report,    // press that must mark the mouse cell
	input  grid_pkg::coord_t       mouse_x,
	input  grid_pkg::coord_t       mouse_y,
	input  logic                   run_end,
	output int                     error_count
);

	localparam int CELLS       = `GRID_SIZE * `GRID_SIZE;
	localparam int FLEET_CELLS = 4 + 4 + 3 + 3 + 2 + 2;  // two ships each of length 4, 3 and 2

	grid_pkg::cell_status_t model [0:CELLS-1];  // reference board in {y, x} addressing
	logic                   scan_req_d = 1'b0;
	logic [1:0]             mode_d;
	logic [2*`COORD_W-1:0]  addr_d;              // cell now showing on pointer_status
	int                     errors = 0;
	int                     captured = 0;        // cells copied from the placed fleet
	int                     clicks = 0;
	int                     marks = 0;           // marker writes seen in the DUT
	logic                   end_seen = 1'b0;

	assign error_count = errors;

	task automatic flag_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	// a shot turns water into a miss and a ship into a hit and leaves shot cells alone
	function automatic grid_pkg::cell_status_t after_shot(input grid_pkg::cell_status_t cur);
		if (cur == `ST_EMPTY) return `ST_MISS;
		if (cur == `ST_SHIP) return `ST_HIT;
		return cur;
	endfunction

	function automatic bit is_ship(input int a, input int dx, input int dy);
		int x = a % `GRID_SIZE + dx;
		int y = a / `GRID_SIZE + dy;
		if (x < 0 || x >= `GRID_SIZE || y < 0 || y >= `GRID_SIZE)
			return 1'b0;  // off board
		return model[y * `GRID_SIZE + x] == `ST_SHIP;
	endfunction

	// every ship is 2 or longer so no ship cell stands alone
	task automatic check_fleet;
		int ships = 0;
		int empties = 0;
		for (int a = 0; a < CELLS; a++) begin
			if (model[a] == `ST_SHIP) begin
				ships++;
				if (!(is_ship(a, 1, 0) || is_ship(a, -1, 0) ||
						is_ship(a, 0, 1) || is_ship(a, 0, -1)))
					flag_error($sformatf("ship cell %0d has no ship neighbor", a));
			end else if (model[a] == `ST_EMPTY) begin
				empties++;
			end
		end
		if (ships != FLEET_CELLS || empties != CELLS - FLEET_CELLS)
			flag_error($sformatf("fleet scan found %0d ship and %0d empty cells",
				ships, empties));
	endtask

	// ----------------------------------------------------------
	// scan compare one clock after the address was set
	// ----------------------------------------------------------
	always @(posedge clk_in) begin
		if (scan_req_d) begin
			case (mode_d)
				2'd0: begin
					if (pointer_status !== `ST_EMPTY || placement_done)
						flag_error($sformatf("cell %0d reads %0d with done %0b before start",
							addr_d, pointer_status, placement_done));
				end
				2'd1: begin
					model[addr_d] = pointer_status;  // copy of the random fleet
					captured++;
					if (captured == CELLS) check_fleet();
				end
				default: begin
					if (pointer_status !== model[addr_d])
						flag_error($sformatf("cell (%0d,%0d) reads %0d, model has %0d",
							addr_d[2:0], addr_d[5:3], pointer_status, model[addr_d]));
				end
			endcase
		end
		if (click_report) begin
			model[{mouse_y, mouse_x}] = after_shot(model[{mouse_y, mouse_x}]);
			clicks++;
		end
		if (mark_we) marks++;  // one write per counted press
		if (run_end && !end_seen) begin
			end_seen = 1'b1;
			if (captured != CELLS) flag_error("placed fleet was never scanned");
			if (marks != clicks)
				flag_error($sformatf("%0d marker writes for %0d clicks", marks, clicks));
		end
		scan_req_d <= scan_req;
		mode_d     <= scan_mode;
		addr_d     <= {pointer_y, pointer_x};
	end

endmodule

// File: tests/grid_engine_tb.sv
`timescale 1ns/10ps

module grid_engine_tb;

	localparam int NUM_CLICKS  = 40;
	localparam int NUM_SCANS   = 8;
	localparam int PLACE_LIMIT = 5000;  // generous, retries are random
	localparam int WATCHDOG    = 16 + NUM_SCANS * 70 + (NUM_CLICKS + 5) * 20 + 80 + PLACE_LIMIT;

	logic                   clk_in;
	logic                   wait_mouse_reset;
	logic                   start;
	logic                   mouse_click;
	grid_pkg::coord_t       mouse_x, mouse_y, pointer_x, pointer_y;
	grid_pkg::cell_status_t pointer_status;
	logic                   placement_done;
	logic                   scan_req, click_report, run_end;
	logic [1:0]             scan_mode;
	int                     error_count;     // from the checker
	int                     tb_errors = 0;
	int                     seed = 32'h9f85;
	int                     r;
	int                     waited;

	tb_clock tb_clock_inst (.clk(clk_in));

	grid_engine grid_engine_inst (
		.clk_in(clk_in), .wait_mouse_reset(wait_mouse_reset), .start(start),
		.mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_click(mouse_click),
		.pointer_x(pointer_x), .pointer_y(pointer_y),
		.pointer_status(pointer_status), .placement_done(placement_done)
	);

	grid_checker grid_checker_inst (
		.clk_in(clk_in), .placement_done(placement_done), .mark_we(grid_engine_inst.mark_we),
		.pointer_x(pointer_x), .pointer_y(pointer_y), .pointer_status(pointer_status),
		.scan_req(scan_req), .scan_mode(scan_mode), .click_report(click_report),
		.mouse_x(mouse_x), .mouse_y(mouse_y), .run_end(run_end), .error_count(error_count)
	);

	task automatic next_cycle;
		@(posedge clk_in);
		#2;  // inputs change 2 ns after the edge
	endtask

	task automatic scan_grid(input logic [1:0] mode);
		scan_mode = mode;
		for (int a = 0; a < 64; a++) begin
			{pointer_y, pointer_x} = 6'(a);
			scan_req = 1'b1;
			next_cycle();
		end
		scan_req = 1'b0;
		repeat (2) next_cycle();  // last registered read reaches the checker
	endtask

	task automatic press_cell(input grid_pkg::coord_t x, input grid_pkg::coord_t y,
			input int hold, input logic counted);
		mouse_x = x;
		mouse_y = y;
		mouse_click = 1'b1;
		click_report = counted;  // model takes the shot once per press
		next_cycle();
		click_report = 1'b0;
		repeat (hold - 1) next_cycle();
		mouse_click = 1'b0;
		r = $random(seed);
		repeat (1 + r[1:0]) next_cycle();  // release gap
		repeat (4) next_cycle();           // cell is written two cycles after the press
	endtask

	task automatic random_click(input logic counted);
		r = $random(seed);
		press_cell(r[2:0], r[5:3], 2 + r[8:6], counted);
	endtask

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin
		wait_mouse_reset = 1'b1;
		start = 1'b0;
		mouse_click = 1'b0;
		mouse_x = '0;
		mouse_y = '0;
		pointer_x = '0;
		pointer_y = '0;
		scan_req = 1'b0;
		scan_mode = 2'd0;
		click_report = 1'b0;
		run_end = 1'b0;
		repeat (16) @(posedge clk_in);
		#2;
		wait_mouse_reset = 1'b0;
		next_cycle();
		scan_grid(2'd0);                  // board is water after reset
		repeat (3) random_click(1'b0);    // no fleet yet, nothing may change
		scan_grid(2'd0);
		mouse_click = 1'b1;               // held through the whole placement
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		waited = 0;
		while (!placement_done && waited < PLACE_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (!placement_done) begin
			$display("placement did not finish within %0d cycles", PLACE_LIMIT);
			tb_errors++;
		end
		repeat (10) next_cycle();
		mouse_click = 1'b0;               // released without a fresh edge
		repeat (4) next_cycle();
		scan_grid(2'd1);                  // checker copies the fleet
		for (int n = 0; n < NUM_CLICKS; n++) begin
			random_click(1'b1);
			if (n % 10 == 9) scan_grid(2'd2);
		end
		press_cell(3'd2, 3'd6, 40, 1'b1);  // long press marks once
		press_cell(3'd2, 3'd6, 3, 1'b1);   // repeat shot keeps the state
		scan_grid(2'd2);
		run_end = 1'b1;
		repeat (2) next_cycle();
		$display("run finished: %0d checker errors, %0d stimulus errors", error_count, tb_errors);
		if (error_count + tb_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG) @(posedge clk_in);
		$display("timeout: the run did not end within %0d cycles", WATCHDOG);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;
	always #10 clk = ~clk;  // 20 ns period, 50 MHz

endmodule
